// File: hdl/link_event_classifier.sv
// link event classifier: sorts each output link's cycle into idle, utilized, stalled, arbitrated
module link_event_classifier (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  noc_dir_pkg::req_matrix_t   req_i,
  input  noc_dir_pkg::req_matrix_t   yumi_i,
  output prof_stat_pkg::link_event_s event_o
);

  prof_stat_pkg::link_event_s event_n;

  // classes for the current cycle, per output direction
  always_comb begin
    int   req_cnt;
    logic any_req;
    logic granted;

    event_n = '0;
    for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
      req_cnt = $countones(req_i[d]);
      any_req = (req_cnt != 0);
      // a grant only counts when it hits a live request
      granted = |(req_i[d] & yumi_i[d]);

      event_n.idle[d]       = !any_req;
      event_n.utilized[d]   = granted;
      event_n.stalled[d]    = any_req && !granted;
      // contention that was resolved this cycle
      event_n.arbitrated[d] = (req_cnt > 1) && granted;
    end
  end

  // one register stage keeps all four vectors on the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_o <= '0;
    end else begin
      event_o <= event_n;
    end
  end

endmodule

// File: hdl/link_stat_bank.sv
// link statistics bank: live event counters and their snapshot copies per direction and class
module link_stat_bank (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  prof_stat_pkg::link_event_s event_i,
  input  logic                       count_en_i,
  input  logic                       clear_i,
  input  logic                       snap_i,
  output prof_stat_pkg::snap_arr_t   snap_cnt_o
);

  // event bits rearranged as [direction][kind]
  logic [noc_dir_pkg::NUM_DIRS-1:0][prof_stat_pkg::NUM_KINDS-1:0] hit;

  prof_stat_pkg::snap_arr_t live_q;
  prof_stat_pkg::snap_arr_t live_n;
  prof_stat_pkg::snap_arr_t snap_q;

  always_comb begin
    for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
      hit[d][prof_stat_pkg::IDLE]       = event_i.idle[d];
      hit[d][prof_stat_pkg::UTILIZED]   = event_i.utilized[d];
      hit[d][prof_stat_pkg::STALLED]    = event_i.stalled[d];
      hit[d][prof_stat_pkg::ARBITRATED] = event_i.arbitrated[d];
    end
  end

  // next live values, wrapping at the counter width
  always_comb begin
    live_n = live_q;
    if (count_en_i) begin
      for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
        for (int k = 0; k < prof_stat_pkg::NUM_KINDS; k++) begin
          live_n[d][k] = live_q[d][k] + prof_stat_pkg::cnt_t'(hit[d][k]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      live_q <= '0;
    end else if (clear_i) begin
      live_q <= '0;
    end else begin
      live_q <= live_n;
    end
  end

  // whole set copied on one edge
  // host always reads counters from the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_q <= '0;
    end else if (clear_i) begin
      snap_q <= '0;
    end else if (snap_i) begin
      snap_q <= live_q;
    end
  end

  assign snap_cnt_o = snap_q;

endmodule

// File: hdl/noc_dir_pkg.sv
// mesh router direction package: port directions and request/grant matrix types
package noc_dir_pkg;

  // local port plus four mesh neighbours
  localparam int NUM_DIRS = 5;

  // bits needed to encode a direction
  localparam int DIR_W = $clog2(NUM_DIRS);

  // same order as the router's port numbering
  typedef enum logic [DIR_W-1:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  // one bit per input port
  typedef logic [NUM_DIRS-1:0] port_vec_t;

  // one bit per output direction
  typedef logic [NUM_DIRS-1:0] dir_vec_t;

  // indexed by output direction, each entry lists the inputs involved
  // used for both the request matrix and the yumi matrix
  typedef port_vec_t [NUM_DIRS-1:0] req_matrix_t;

endpackage

// File: hdl/prof_stat_pkg.sv
// profiler statistics package: counter, event, control and register address types
`include "router_prof_params.svh"

package prof_stat_pkg;

  // one live or snapshot counter
  typedef logic [`PROF_CNT_W-1:0] cnt_t;

  // number of event classes per output direction
  localparam int NUM_KINDS = 4;
  localparam int KIND_W = $clog2(NUM_KINDS);

  // event class, also the kind field of a counter address
  typedef enum logic [KIND_W-1:0] {
    IDLE       = 2'd0,
    UTILIZED   = 2'd1,
    STALLED    = 2'd2,
    ARBITRATED = 2'd3
  } stat_kind_e;

  // per-cycle classification, one bit per output direction in each class
  typedef struct packed {
    noc_dir_pkg::dir_vec_t idle;
    noc_dir_pkg::dir_vec_t utilized;
    noc_dir_pkg::dir_vec_t stalled;
    noc_dir_pkg::dir_vec_t arbitrated;
  } link_event_s;

  // host control bundle, clear and snap_req are single-cycle pulses
  typedef struct packed {
    logic count_en;
    logic periodic_en;
    logic clear;
    logic snap_req;
  } prof_ctrl_s;

  // sequence number of snapshots taken
  typedef logic [`PROF_SNAP_CNT_W-1:0] snap_count_t;

  // wishbone byte address
  typedef logic [`PROF_ADDR_W-1:0] reg_addr_t;

  // full counter set, indexed [direction][kind]
  typedef cnt_t [noc_dir_pkg::NUM_DIRS-1:0][NUM_KINDS-1:0] snap_arr_t;

endpackage

// File: hdl/prof_wb_slave.sv
// profiler wishbone classic slave: control register, snapshot command and counter readout
`include "router_prof_params.svh"

module prof_wb_slave (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  prof_stat_pkg::reg_addr_t   wb_adr_i,
  input  prof_stat_pkg::cnt_t        wb_dat_i,
  output prof_stat_pkg::cnt_t        wb_dat_o,
  output logic                       wb_ack_o,
  input  prof_stat_pkg::snap_arr_t   snap_cnt_i,
  input  prof_stat_pkg::snap_count_t snap_count_i,
  output prof_stat_pkg::prof_ctrl_s  ctrl_o
);

  // strobe already answered, cleared once stb or cyc drops
  logic served_q;
  logic access;
  logic wr_ctrl;
  logic wr_snap;

  prof_stat_pkg::reg_addr_t   cnt_off;
  logic                       cnt_hit;
  noc_dir_pkg::dir_e          rd_dir;
  prof_stat_pkg::stat_kind_e  rd_kind;
  prof_stat_pkg::cnt_t        rd_data;

  assign access  = wb_cyc_i && wb_stb_i && !served_q;
  assign wr_ctrl = access && wb_we_i && (wb_adr_i == `PROF_REG_CTRL);
  assign wr_snap = access && wb_we_i && (wb_adr_i == `PROF_REG_SNAP);

  // counter window: 16 bytes per direction, one word per kind
  assign cnt_off = wb_adr_i - `PROF_REG_CNT_BASE;
  assign cnt_hit = (wb_adr_i >= `PROF_REG_CNT_BASE)
                && (cnt_off[`PROF_ADDR_W-1:4] < noc_dir_pkg::NUM_DIRS)
                && (cnt_off[1:0] == 2'b00);

  always_comb begin
    rd_dir  = noc_dir_pkg::P;
    rd_kind = prof_stat_pkg::IDLE;
    if (cnt_hit) begin
      rd_dir  = noc_dir_pkg::dir_e'(cnt_off[4 +: noc_dir_pkg::DIR_W]);
      rd_kind = prof_stat_pkg::stat_kind_e'(cnt_off[2 +: prof_stat_pkg::KIND_W]);
    end
  end

  // unmapped addresses read as zero
  always_comb begin
    rd_data = '0;
    if (wb_adr_i == `PROF_REG_CTRL) begin
      rd_data = prof_stat_pkg::cnt_t'({ctrl_o.periodic_en, ctrl_o.count_en});
    end else if (wb_adr_i == `PROF_REG_STATUS) begin
      rd_data = prof_stat_pkg::cnt_t'(snap_count_i);
    end else if (cnt_hit) begin
      rd_data = snap_cnt_i[rd_dir][rd_kind];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
      served_q <= 1'b0;
      ctrl_o   <= '0;
    end else begin
      wb_ack_o        <= access;
      served_q        <= wb_cyc_i && wb_stb_i && (served_q || access);
      ctrl_o.clear    <= wr_ctrl && wb_dat_i[`PROF_CTRL_CLEAR];
      ctrl_o.snap_req <= wr_snap;
      if (wr_ctrl) begin
        ctrl_o.count_en    <= wb_dat_i[`PROF_CTRL_CNT_EN];
        ctrl_o.periodic_en <= wb_dat_i[`PROF_CTRL_PER_EN];
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

// File: hdl/router_prof_params.svh
// router profiler parameters: counter width, snapshot period and host register map
`ifndef ROUTER_PROF_PARAMS_SVH
`define ROUTER_PROF_PARAMS_SVH

// one bus word per counter
`define PROF_CNT_W 32

// cycles between periodic snapshots
`define PROF_PERIOD 64

// width of the snapshot sequence count
`define PROF_SNAP_CNT_W 16

// wishbone byte address width
`define PROF_ADDR_W 8

// register byte addresses
`define PROF_REG_CTRL     8'h00
`define PROF_REG_SNAP     8'h04
`define PROF_REG_STATUS   8'h08
`define PROF_REG_CNT_BASE 8'h40

// control register bit positions
`define PROF_CTRL_CNT_EN 0
`define PROF_CTRL_PER_EN 1
`define PROF_CTRL_CLEAR  2

`endif

// File: hdl/router_profiler_top.sv
// router profiler top: link classifier, window control, stat bank and host register block
`include "router_prof_params.svh"

module router_profiler_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  noc_dir_pkg::req_matrix_t req_i,
  input  noc_dir_pkg::req_matrix_t yumi_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`PROF_ADDR_W-1:0]  wb_adr_i,
  input  logic [`PROF_CNT_W-1:0]   wb_dat_i,
  output logic [`PROF_CNT_W-1:0]   wb_dat_o,
  output logic                     wb_ack_o
);

  prof_stat_pkg::link_event_s link_event;
  prof_stat_pkg::prof_ctrl_s  ctrl;
  prof_stat_pkg::snap_arr_t   snap_cnt;
  prof_stat_pkg::snap_count_t snap_count;
  logic                       snap;

  link_event_classifier u_classifier (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .yumi_i  (yumi_i),
    .event_o (link_event)
  );

  sample_window_ctrl u_window (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .periodic_en_i (ctrl.periodic_en),
    .snap_req_i    (ctrl.snap_req),
    .clear_i       (ctrl.clear),
    .snap_o        (snap),
    .snap_count_o  (snap_count)
  );

  link_stat_bank u_stat_bank (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .event_i    (link_event),
    .count_en_i (ctrl.count_en),
    .clear_i    (ctrl.clear),
    .snap_i     (snap),
    .snap_cnt_o (snap_cnt)
  );

  prof_wb_slave u_wb_slave (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .snap_cnt_i   (snap_cnt),
    .snap_count_i (snap_count),
    .ctrl_o       (ctrl)
  );

endmodule

// File: hdl/sample_window_ctrl.sv
// sample window controller with period timer, snapshot strobe and snapshot sequence count
`include "router_prof_params.svh"

module sample_window_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       periodic_en_i,
  input  logic                       snap_req_i,
  input  logic                       clear_i,
  output logic                       snap_o,
  output prof_stat_pkg::snap_count_t snap_count_o
);

  localparam int TMR_W = $clog2(`PROF_PERIOD + 1);
  localparam logic [TMR_W-1:0] RELOAD = TMR_W'(`PROF_PERIOD);

  // cycles left in the current window
  logic [TMR_W-1:0] timer_q;
  logic             expire;

  // last cycle of the window
  assign expire = periodic_en_i && (timer_q == TMR_W'(1));

  // held at reload while disabled, so counting restarts when periodic_en rises
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      timer_q <= RELOAD;
    end else if (clear_i) begin
      timer_q <= RELOAD;
    end else if (!periodic_en_i || expire) begin
      timer_q <= RELOAD;
    end else begin
      timer_q <= timer_q - 1'b1;
    end
  end

  // host request and expiry on the same edge merge into one pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_o <= 1'b0;
    end else if (clear_i) begin
      snap_o <= 1'b0;
    end else begin
      snap_o <= snap_req_i || expire;
    end
  end

  // one step per snapshot pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_count_o <= '0;
    end else if (clear_i) begin
      snap_count_o <= '0;
    end else if (snap_o) begin
      snap_count_o <= snap_count_o + 1'b1;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the router profiler testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module router_profiler_tb \
       -f tb.f -o router_profiler_sim \
  && ./obj_dir/router_profiler_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+hdl
hdl/noc_dir_pkg.sv
hdl/prof_stat_pkg.sv
hdl/link_event_classifier.sv
hdl/sample_window_ctrl.sv
hdl/link_stat_bank.sv
hdl/prof_wb_slave.sv
hdl/router_profiler_top.sv
test/router_profiler_assert.sv
test/router_profiler_tb.sv

// File: test/router_profiler_assert.sv
// profiler assertions: wishbone ack handshake and link event class consistency
module router_profiler_assert (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       wb_cyc_i,
  input logic                       wb_stb_i,
  input logic                       wb_ack_i,
  input prof_stat_pkg::link_event_s event_i
);

  // ack only answers a live strobe
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("ack seen without cyc and stb");

  ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("ack high on two cycles in a row");

  // an idle link can be neither busy nor blocked
  idle_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    (event_i.idle & (event_i.utilized | event_i.stalled)) == '0)
    else $error("idle event together with utilized or stalled");

  arb_needs_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    (event_i.arbitrated & ~event_i.utilized) == '0)
    else $error("arbitrated event without utilized");

endmodule

bind prof_wb_slave router_profiler_assert u_bus_assert (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_i (wb_ack_o),
  .event_i  ('0)
);

bind link_event_classifier router_profiler_assert u_event_assert (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .wb_cyc_i (1'b0),
  .wb_stb_i (1'b0),
  .wb_ack_i (1'b0),
  .event_i  (event_o)
);

// File: test/router_profiler_tb.sv
// router profiler testbench: directed tests against a cycle model of the link counters
`include "router_prof_params.svh"

module router_profiler_tb;

  localparam int ACK_WAIT = 8;
  localparam int TEST_CYCLES = 40 + 220 + 160 + 380 + (5 * `PROF_PERIOD + 60) + 120;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  noc_dir_pkg::req_matrix_t req_i;
  noc_dir_pkg::req_matrix_t yumi_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`PROF_ADDR_W-1:0]  wb_adr_i;
  prof_stat_pkg::cnt_t      wb_dat_i;
  prof_stat_pkg::cnt_t      wb_dat_o;
  logic                     wb_ack_o;

  // reference counters, [direction][kind]
  prof_stat_pkg::cnt_t model_cnt [noc_dir_pkg::NUM_DIRS][prof_stat_pkg::NUM_KINDS];
  logic        model_en = 1'b0;
  logic        en_pending = 1'b0;
  logic        pending_en = 1'b0;
  int          exp_snaps = 0;
  int          checks = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  logic [31:0] seed;

  router_profiler_top uut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .yumi_i   (yumi_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // class bits of one output: [0] idle, [1] utilized, [2] stalled, [3] arbitrated
  function automatic logic [3:0] link_class(noc_dir_pkg::port_vec_t req,
                                            noc_dir_pkg::port_vec_t yumi);
    int   n;
    logic grant;
    n = 0;
    for (int i = 0; i < noc_dir_pkg::NUM_DIRS; i++) begin
      n += int'(req[i]);
    end
    grant = |(req & yumi);
    link_class[0] = (req == '0);
    link_class[1] = grant;
    link_class[2] = (n > 0) && !grant;
    link_class[3] = (n >= 2) && grant;
  endfunction

  task automatic check_val(string name, prof_stat_pkg::cnt_t got, prof_stat_pkg::cnt_t exp);
    checks++;
    assert (got == exp) else begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // advance one cycle and book the inputs held over it into the model
  task automatic tick();
    logic [3:0] cls;
    @(negedge clk_i);
    if (en_pending && wb_ack_o) begin
      model_en = pending_en;
      en_pending = 1'b0;
    end
    if (model_en) begin
      for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
        cls = link_class(req_i[d], yumi_i[d]);
        for (int k = 0; k < prof_stat_pkg::NUM_KINDS; k++) begin
          model_cnt[d][k] += prof_stat_pkg::cnt_t'(cls[k]);
        end
      end
    end
  endtask

  task automatic wb_access(input logic we, input prof_stat_pkg::reg_addr_t adr,
                           input prof_stat_pkg::cnt_t wdata, output prof_stat_pkg::cnt_t rdata);
    int   waited;
    logic acked;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    acked = 1'b0;
    waited = 0;
    rdata = '0;
    while (!acked && waited < ACK_WAIT) begin
      tick();
      waited++;
      acked = wb_ack_o;
      if (acked) rdata = wb_dat_o;
    end
    checks++;
    assert (acked) else begin
      $display("no ack from the slave for the access at address %h", adr);
      errors++;
    end
    // strobe stays up through the edge that samples ack
    tick();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    tick();
  endtask

  task automatic wb_write(prof_stat_pkg::reg_addr_t adr, prof_stat_pkg::cnt_t data);
    prof_stat_pkg::cnt_t unused;
    if (adr == `PROF_REG_CTRL) begin
      pending_en = data[`PROF_CTRL_CNT_EN];
      en_pending = 1'b1;
    end
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(prof_stat_pkg::reg_addr_t adr, output prof_stat_pkg::cnt_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic take_snapshot();
    wb_write(`PROF_REG_SNAP, '0);
    exp_snaps++;
    repeat (4) tick();
  endtask

  task automatic compare_counters();
    prof_stat_pkg::reg_addr_t adr;
    prof_stat_pkg::cnt_t      v;
    for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
      for (int k = 0; k < prof_stat_pkg::NUM_KINDS; k++) begin
        adr = `PROF_REG_CNT_BASE + prof_stat_pkg::reg_addr_t'(d * 16 + k * 4);
        wb_read(adr, v);
        check_val($sformatf("wb_dat_o cnt[%0d][%0d]", d, k), v, model_cnt[d][k]);
      end
    end
  endtask

  task automatic compare_snap_count();
    prof_stat_pkg::cnt_t v;
    wb_read(`PROF_REG_STATUS, v);
    check_val("wb_dat_o snap_count", v, prof_stat_pkg::cnt_t'(exp_snaps));
  endtask

  task automatic set_pattern(int d, int pat);
    case (pat)
      0: begin
        req_i[d]  = '0;
        yumi_i[d] = '0;
      end
      1: begin
        req_i[d]  = noc_dir_pkg::port_vec_t'(1) << ((d + 1) % 5);
        yumi_i[d] = req_i[d];
      end
      2: begin
        req_i[d]  = noc_dir_pkg::port_vec_t'(1) << ((d + 2) % 5);
        yumi_i[d] = '0;
      end
      default: begin
        req_i[d]  = 5'b10101;
        yumi_i[d] = 5'b00100;
      end
    endcase
  endtask

  task automatic report_test(string name, int err_before);
    $display("%s: finished with %0d errors", name, errors - err_before);
  endtask

  task automatic check_reset_values();
    int                  e0;
    prof_stat_pkg::cnt_t v;
    e0 = errors;
    wb_read(`PROF_REG_CTRL, v);
    check_val("wb_dat_o ctrl", v, '0);
    wb_read(`PROF_REG_STATUS, v);
    check_val("wb_dat_o status", v, '0);
    wb_read(8'h40, v);
    check_val("wb_dat_o cnt[0][0]", v, '0);
    wb_read(8'h5c, v);
    check_val("wb_dat_o cnt[1][3]", v, '0);
    wb_read(8'h8c, v);
    check_val("wb_dat_o cnt[4][3]", v, '0);
    report_test("reset values", e0);
  endtask

  task automatic run_directed_patterns();
    int e0;
    e0 = errors;
    wb_write(`PROF_REG_CTRL, 32'h1);
    // every direction meets every pattern, each held for a different length
    for (int p = 0; p < 4; p++) begin
      for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
        set_pattern(d, (p + d) % 4);
      end
      repeat (5 + 2 * p) tick();
    end
    req_i = '0;
    yumi_i = '0;
    wb_write(`PROF_REG_CTRL, 32'h0);
    repeat (4) tick();
    take_snapshot();
    compare_counters();
    compare_snap_count();
    report_test("directed patterns", e0);
  endtask

  task automatic verify_count_disable();
    int e0;
    e0 = errors;
    for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
      set_pattern(d, 3);
    end
    repeat (20) tick();
    req_i = '0;
    yumi_i = '0;
    repeat (4) tick();
    take_snapshot();
    compare_counters();
    compare_snap_count();
    report_test("count disabled", e0);
  endtask

  task automatic run_random_traffic();
    int                  e0;
    logic [31:0]         r;
    prof_stat_pkg::cnt_t v;
    e0 = errors;
    wb_write(`PROF_REG_CTRL, 32'h1);
    repeat (200) begin
      r = $urandom;
      req_i = r[24:0];
      r = $urandom;
      yumi_i = r[24:0];
      tick();
    end
    req_i = '0;
    yumi_i = '0;
    wb_write(`PROF_REG_CTRL, 32'h0);
    repeat (4) tick();
    take_snapshot();
    compare_counters();
    compare_snap_count();
    wb_read(8'h0c, v);
    check_val("wb_dat_o unmapped 0x0c", v, '0);
    wb_read(8'ha0, v);
    check_val("wb_dat_o unmapped 0xa0", v, '0);
    report_test("random traffic", e0);
  endtask

  task automatic verify_periodic_snaps();
    int e0;
    e0 = errors;
    wb_write(`PROF_REG_CTRL, 32'h2);
    repeat (5 * `PROF_PERIOD + 2) tick();
    wb_write(`PROF_REG_CTRL, 32'h0);
    exp_snaps += 5;
    compare_snap_count();
    report_test("periodic snapshots", e0);
  endtask

  task automatic verify_clear();
    int e0;
    e0 = errors;
    wb_write(`PROF_REG_CTRL, 32'h4);
    repeat (2) tick();
    for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
      for (int k = 0; k < prof_stat_pkg::NUM_KINDS; k++) begin
        model_cnt[d][k] = '0;
      end
    end
    exp_snaps = 0;
    compare_counters();
    compare_snap_count();
    report_test("clear", e0);
  endtask

  initial begin
    reset_i  = 1'b1;
    req_i    = '0;
    yumi_i   = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    for (int d = 0; d < noc_dir_pkg::NUM_DIRS; d++) begin
      for (int k = 0; k < prof_stat_pkg::NUM_KINDS; k++) begin
        model_cnt[d][k] = '0;
      end
    end
    seed = $urandom(32'h1e2f96d0);
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    check_reset_values();
    run_directed_patterns();
    verify_count_disable();
    run_random_traffic();
    verify_periodic_snaps();
    verify_clear();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
